// File: project.f
rtl/video_timing_pkg.sv
rtl/crop_regs_pkg.sv
rtl/line_measure.sv
rtl/frame_measure.sv
rtl/crop_regs.sv
rtl/video_crop_top.sv
verif/crop_checker.sv
verif/tb_video_crop.sv

// File: run.sh
#!/bin/sh
# build and run the video crop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_video_crop -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log && echo "simulation ok" && exit 0 || exit 1

// File: verif/tb_video_crop.sv
/*
 * video crop testbench
 * clock, reset, progressive video timing, Wishbone and keyboard stimulus
 */
`timescale 1ns/1ps

module tb_video_crop;
	import crop_regs_pkg::*;

	localparam int cnt_w   = video_timing_pkg::cnt_w_default;
	localparam int dat_w   = crop_regs_pkg::wb_dat_w;
	localparam int h_total = 100;
	localparam int v_total = 30;
	localparam int h_sync  = 8;
	localparam int v_sync  = 2;
	localparam int h_start = 24;	// first active clock in the line
	localparam int v_start = 5;	// first active line in the frame

	logic                clk_sys = 1'b0;
	logic                reset;
	logic                hs;
	logic                vs;
	logic                hblank;
	logic                vblank;
	logic                kbd_level;
	logic [1:0]          kbd_type;
	logic [7:0]          kbd_data;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [wb_adr_w-1:0] wb_adr;
	logic [dat_w-1:0]    wb_dat_w;
	logic [dat_w-1:0]    wb_dat_r;
	logic                wb_ack;
	logic                de;
	int                  hpos;
	int                  vpos;
	int                  h_act;
	int                  v_act;
	int                  next_h_act;
	int                  next_v_act;
	int                  frame_cnt;
	int                  max_lat;
	int                  err_cnt;
	int                  base;
	logic                timed_out;
	logic [dat_w-1:0]    wr_val [4];

	always #4 clk_sys = ~clk_sys;

	video_crop_top #(.cnt_w(cnt_w)) u_video_crop_top (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .vs(vs), .hblank(hblank),
		.vblank(vblank), .kbd_level(kbd_level), .kbd_type(kbd_type), .kbd_data(kbd_data),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .de(de)
	);

	crop_checker u_crop_checker (
		.clk_sys(clk_sys), .reset(reset), .vs(vs), .de(de), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_ack(wb_ack), .err_cnt(err_cnt), .timed_out(timed_out)
	);

	// video timing, geometry switches just after the active lines begin
	always @(posedge clk_sys) begin
		hpos   <= (hpos == h_total - 1) ? 0 : hpos + 1;
		if (hpos == h_total - 1) begin
			vpos <= (vpos == v_total - 1) ? 0 : vpos + 1;
			if (vpos == v_total - 1)
				frame_cnt <= frame_cnt + 1;
			if (vpos == v_start) begin
				h_act <= next_h_act;
				v_act <= next_v_act;
			end
		end
		hs     <= !(hpos < h_sync);
		hblank <= !(hpos >= h_start && hpos < h_start + h_act);
		vs     <= !(vpos < v_sync);
		vblank <= !(vpos >= v_start && vpos < v_start + v_act);
	end

	always @(posedge clk_sys) begin
		if (timed_out) begin
			$display("test failed");
			$finish;
		end
	end

	task automatic wb_access(input logic we, input logic [wb_adr_w-1:0] adr,
			input logic [dat_w-1:0] wdat, output logic [dat_w-1:0] rdat);
		int n;
		n = 0;
		@(posedge clk_sys);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!wb_ack && n < 16);
		if (!wb_ack)
			u_crop_checker.note_error("no ack from the register block");
		if (n - 1 > max_lat)
			max_lat = n - 1;	// cycles from strobe to ack
		rdat = wb_dat_r;
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic write_reg(input logic [wb_adr_w-1:0] adr, input int val);
		logic [dat_w-1:0] dummy;
		wb_access(1'b1, adr, dat_w'(val), dummy);
	endtask

	task automatic read_reg(input logic [wb_adr_w-1:0] adr, output int val);
		logic [dat_w-1:0] d;
		wb_access(1'b0, adr, '0, d);
		val = int'(d);
	endtask

	task automatic read_check(input string name, input logic [wb_adr_w-1:0] adr, input int exp);
		int v;
		read_reg(adr, v);
		u_crop_checker.check_value(name, exp, v);
	endtask

	// key event is a toggle of the level line
	task automatic send_key(input logic [7:0] code);
		@(posedge clk_sys);
		kbd_type  <= kbd_type_key;
		kbd_data  <= code;
		kbd_level <= ~kbd_level;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target)
			@(negedge clk_sys);
	endtask

	initial begin
		void'($urandom(32'hef58_b527));
		{reset, kbd_level, wb_cyc, wb_stb, wb_we} = 5'b10000;
		kbd_type   = 2'd0;
		kbd_data   = 8'd0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		hpos       = 0;
		vpos       = 0;
		frame_cnt  = 0;
		max_lat    = 0;
		h_act      = 64;
		next_h_act = 64;
		v_act      = 20;
		next_v_act = 20;
		{hs, vs, hblank, vblank} = 4'b1111;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		for (int i = 0; i < 4; i++) begin
			wr_val[i] = dat_w'($urandom % 21);
			write_reg(wb_adr_w'(i), int'(wr_val[i]));
		end
		read_check("register left", reg_left, int'(wr_val[0]));
		read_check("register right", reg_right, int'(wr_val[1]));
		read_check("register top", reg_top, int'(wr_val[2]));
		read_check("register bottom", reg_bottom, int'(wr_val[3]));
		u_crop_checker.check_value("register ack latency", 1, max_lat);

		wait_frames(3);
		read_check("measured hsize", reg_hsize, 64);
		read_check("measured vsize", reg_vsize, 20);

		for (int i = 0; i < 4; i++)
			write_reg(wb_adr_w'(i), 0);
		send_key({1'b0, key_up});
		send_key({1'b0, key_left});
		send_key({1'b0, key_alt_l});
		send_key({1'b0, key_left});
		send_key({1'b0, key_down});
		send_key({1'b1, key_alt_l});
		read_check("key top", reg_top, 1);
		read_check("key left", reg_left, 4);
		read_check("key right", reg_right, 4);
		read_check("key bottom", reg_bottom, (1 << cnt_w) - 1);
		send_key({1'b0, key_clear});
		for (int i = 0; i < 4; i++)
			read_check($sformatf("key clear %0d", i), wb_adr_w'(i), 0);

		write_reg(reg_left, 4);
		write_reg(reg_right, 8);
		write_reg(reg_top, 2);
		write_reg(reg_bottom, 3);
		wait_frames(3);
		u_crop_checker.check_de_count("crop effect", 64, 20, 4, 8, 2, 3);

		read_reg(reg_change, base);
		next_h_act = 48;
		next_v_act = 16;
		wait_frames(3);
		next_h_act = 64;
		next_v_act = 20;
		wait_frames(3);
		read_check("change counter", reg_change, (base + 2) % 128);
		read_check("hsize after change", reg_hsize, 64);

		u_crop_checker.summary();
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: verif/crop_checker.sv
/*
 * crop checker
 * counts de per frame, watches the bus ack, compares results and
 * ends a run that takes too long
 */
`timescale 1ns/1ps

module crop_checker (
	input  logic clk_sys,
	input  logic reset,
	input  logic vs,
	input  logic de,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_ack,
	output int   err_cnt,
	output logic timed_out
);
	localparam int frame_clks = 3000;
	localparam int max_frames = 20;

	int   checks = 0;
	int   de_cnt = 0;
	int   last_de = 0;
	int   cycles = 0;
	logic vs_q = 1'b1;
	logic ack_q = 1'b0;
	logic req_q = 1'b0;

	initial begin
		err_cnt   = 0;
		timed_out = 1'b0;
	end

	// active clocks left after the crop
	function automatic int expected_de_count(input int h, input int v, input int l,
			input int r, input int t, input int b);
		return (h - l - r) * (v - t - b);
	endfunction

	task automatic note_error(input string what);
		err_cnt++;
		$display("ERROR %s", what);
	endtask

	task automatic check_value(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			err_cnt++;
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
		end else
			$display("ok   %s = %0d", name, act);
	endtask

	task automatic check_de_count(input string name, input int h, input int v, input int l,
			input int r, input int t, input int b);
		check_value(name, expected_de_count(h, v, l, r, t, b), last_de);
	endtask

	task automatic summary();
		$display("checks run %0d, failed %0d", checks, err_cnt);
	endtask

	// de per frame, closed at each vsync fall
	always @(posedge clk_sys) begin
		vs_q <= vs;
		if (vs_q && !vs) begin
			last_de <= de_cnt;
			de_cnt  <= 0;
		end else if (de)
			de_cnt <= de_cnt + 1;
	end

	always @(posedge clk_sys) begin
		ack_q <= wb_ack;
		req_q <= wb_cyc & wb_stb & ~wb_ack;
		if (!reset && wb_ack && ack_q)
			note_error("ack stayed high for more than one cycle");
		if (!reset && wb_ack && !req_q)
			note_error("ack came without a request");
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == max_frames * frame_clks && !timed_out) begin
			$display("run stopped: the tests did not finish within %0d cycles", cycles);
			timed_out <= 1'b1;
		end
	end

endmodule

// File: rtl/video_crop_top.sv
/*
 * video crop top level
 * register block beside the line and frame measurement blocks
 */
`timescale 1ns/1ps

module video_crop_top #(
	parameter int cnt_w = video_timing_pkg::cnt_w_default
) (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               hs,	// active low
	input  logic                               vs,	// active low
	input  logic                               hblank,
	input  logic                               vblank,
	input  logic                               kbd_level,
	input  logic [1:0]                         kbd_type,
	input  logic [7:0]                         kbd_data,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [crop_regs_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [crop_regs_pkg::wb_dat_w-1:0] wb_dat_w,
	output logic [crop_regs_pkg::wb_dat_w-1:0] wb_dat_r,
	output logic                               wb_ack,
	output logic                               de
);

	logic [cnt_w-1:0] crop_left;
	logic [cnt_w-1:0] crop_right;
	logic [cnt_w-1:0] crop_top;
	logic [cnt_w-1:0] crop_bottom;
	logic             line_start;
	logic             hbl_fall;
	logic             h_active;
	logic [cnt_w-1:0] hsize;
	logic             frame_start;
	logic [cnt_w-1:0] vsize;

	crop_regs #(
		.cnt_w(cnt_w)
	) u_crop_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.kbd_level  (kbd_level),
		.kbd_type   (kbd_type),
		.kbd_data   (kbd_data),
		.frame_start(frame_start),
		.hsize      (hsize),
		.vsize      (vsize),
		.crop_left  (crop_left),
		.crop_right (crop_right),
		.crop_top   (crop_top),
		.crop_bottom(crop_bottom)
	);

	line_measure #(
		.cnt_w(cnt_w)
	) u_line_measure (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.hs        (hs),
		.hblank    (hblank),
		.crop_left (crop_left),
		.crop_right(crop_right),
		.line_start(line_start),
		.hbl_fall  (hbl_fall),
		.h_active  (h_active),
		.hsize     (hsize)
	);

	frame_measure #(
		.cnt_w(cnt_w)
	) u_frame_measure (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.vs         (vs),
		.vblank     (vblank),
		.line_start (line_start),
		.hbl_fall   (hbl_fall),
		.h_active   (h_active),
		.crop_top   (crop_top),
		.crop_bottom(crop_bottom),
		.frame_start(frame_start),
		.vsize      (vsize),
		.de         (de)
	);

endmodule

// File: rtl/crop_regs.sv
/*
 * crop register block
 * Wishbone classic slave holding the four crop offsets, arrow key
 * adjustment of the offsets, and a per-frame snapshot of the
 * measured size with a geometry change counter
 */
`timescale 1ns/1ps

module crop_regs #(
	parameter int cnt_w = video_timing_pkg::cnt_w_default
) (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [crop_regs_pkg::wb_adr_w-1:0] wb_adr,
	input  logic [crop_regs_pkg::wb_dat_w-1:0] wb_dat_w,
	output logic [crop_regs_pkg::wb_dat_w-1:0] wb_dat_r,
	output logic                               wb_ack,
	input  logic                               kbd_level,
	input  logic [1:0]                         kbd_type,
	input  logic [7:0]                         kbd_data,
	input  logic                               frame_start,
	input  logic [cnt_w-1:0]                   hsize,
	input  logic [cnt_w-1:0]                   vsize,
	output logic [cnt_w-1:0]                   crop_left,
	output logic [cnt_w-1:0]                   crop_right,
	output logic [cnt_w-1:0]                   crop_top,
	output logic [cnt_w-1:0]                   crop_bottom
);
	import crop_regs_pkg::*;

	logic                       wb_req;
	logic                       wb_wr;
	logic                       kbd_level_q;
	logic                       key_evt;
	logic                       key_valid;
	key_byte_u                  key_q;
	logic                       alt;
	logic [cnt_w-1:0]           snap_hsize;
	logic [cnt_w-1:0]           snap_vsize;
	logic [6:0]                 change_cnt;
	logic [$bits(wb_dat_r)-1:0] rd_data;

	assign wb_req  = wb_cyc & wb_stb & ~wb_ack;	// single cycle ack, no wait
	assign wb_wr   = wb_req & wb_we;
	assign key_evt = (kbd_level ^ kbd_level_q) && (kbd_type == kbd_type_key);

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			reg_left:   rd_data[cnt_w-1:0] = crop_left;
			reg_right:  rd_data[cnt_w-1:0] = crop_right;
			reg_top:    rd_data[cnt_w-1:0] = crop_top;
			reg_bottom: rd_data[cnt_w-1:0] = crop_bottom;
			reg_hsize:  rd_data[cnt_w-1:0] = snap_hsize;
			reg_vsize:  rd_data[cnt_w-1:0] = snap_vsize;
			reg_change: rd_data[6:0]       = change_cnt;
			default:    rd_data            = '0;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_req;
	end

	always_ff @(posedge clk_sys) begin
		if (wb_req)
			wb_dat_r <= rd_data;	// valid with ack
		if (key_evt)
			key_q.raw <= kbd_data;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			kbd_level_q <= 1'b0;
			key_valid   <= 1'b0;
		end else begin
			kbd_level_q <= kbd_level;
			key_valid   <= key_evt;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			crop_left   <= '0;
			crop_right  <= '0;
			crop_top    <= '0;
			crop_bottom <= '0;
			alt         <= 1'b0;
		end else begin
			if (key_valid) begin
				if (key_q.raw == {1'b0, key_clear}) begin
					crop_left   <= '0;
					crop_right  <= '0;
					crop_top    <= '0;
					crop_bottom <= '0;
				end else if (key_q.raw == {1'b0, key_up}) begin
					if (alt) crop_bottom <= crop_bottom + 1'b1;
					else     crop_top    <= crop_top + 1'b1;
				end else if (key_q.raw == {1'b0, key_down}) begin
					if (alt) crop_bottom <= crop_bottom - 1'b1;
					else     crop_top    <= crop_top - 1'b1;
				end else if (key_q.raw == {1'b0, key_left}) begin
					if (alt) crop_right <= crop_right + cnt_w'(h_step);
					else     crop_left  <= crop_left + cnt_w'(h_step);
				end else if (key_q.raw == {1'b0, key_right}) begin
					if (alt) crop_right <= crop_right - cnt_w'(h_step);
					else     crop_left  <= crop_left - cnt_w'(h_step);
				end else if (key_q.fld.code == key_alt_l || key_q.fld.code == key_alt_r) begin
					alt <= ~key_q.fld.rel;	// held until release
				end
			end

			// host write overrides a key on the same edge
			if (wb_wr) begin
				case (wb_adr)
					reg_left:   crop_left   <= wb_dat_w[cnt_w-1:0];
					reg_right:  crop_right  <= wb_dat_w[cnt_w-1:0];
					reg_top:    crop_top    <= wb_dat_w[cnt_w-1:0];
					reg_bottom: crop_bottom <= wb_dat_w[cnt_w-1:0];
					default:    ;	// read only or unmapped
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			snap_hsize <= '0;
			snap_vsize <= '0;
			change_cnt <= '0;
		end else if (frame_start) begin
			snap_hsize <= hsize;
			snap_vsize <= vsize;
			if (snap_hsize != hsize || snap_vsize != vsize)
				change_cnt <= change_cnt + 1'b1;	// wraps at 128
		end
	end

endmodule

// File: rtl/frame_measure.sv
/*
 * frame measurement
 * counts lines, captures the vblank edges and the frame length,
 * measures the active height and combines the vertical soft and
 * forced blank with the line timing into the data enable
 */
`timescale 1ns/1ps

module frame_measure #(
	parameter int cnt_w = video_timing_pkg::cnt_w_default
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             vs,
	input  logic             vblank,
	input  logic             line_start,
	input  logic             hbl_fall,
	input  logic             h_active,
	input  logic [cnt_w-1:0] crop_top,
	input  logic [cnt_w-1:0] crop_bottom,
	output logic             frame_start,
	output logic [cnt_w-1:0] vsize,
	output logic             de
);
	import video_timing_pkg::*;

	logic             vs_q;
	logic             vblank_q;
	logic [cnt_w-1:0] vcnt;
	logic [cnt_w-1:0] vend;	// line count at vblank fall
	logic [cnt_w-1:0] vsta;	// line count at vblank rise
	logic [cnt_w-1:0] vmax;
	logic             vblank_fall;
	logic             vblank_rise;
	logic             vs_fall;
	logic             svbl;
	logic             fvbl;
	logic             svbl_nxt;
	logic             fvbl_nxt;
	logic             vbl_line;
	logic [cnt_w-1:0] soft_off;
	logic [cnt_w-1:0] soft_on;

	assign vblank_fall = vblank_q & ~vblank;
	assign vblank_rise = ~vblank_q & vblank;
	assign vs_fall     = vs_q & ~vs;

	// vend and vsta hold the count of the line before each edge
	assign soft_off = vend + crop_top + cnt_w'(1);
	assign soft_on  = vsta - crop_bottom + cnt_w'(1);	// previous frame's vsta

	// vertical blank state for the line now starting
	always_comb begin
		svbl_nxt = svbl;
		fvbl_nxt = fvbl;
		if (vcnt == soft_off)
			svbl_nxt = 1'b0;
		if (vcnt == soft_on)
			svbl_nxt = 1'b1;
		if (vcnt == cnt_w'(v_force_lead))
			fvbl_nxt = 1'b0;
		if (vcnt == vmax - cnt_w'(v_force_trail))
			fvbl_nxt = 1'b1;
	end

	// on the first active clock of a line the update is not registered yet
	assign vbl_line = hbl_fall ? (svbl_nxt | fvbl_nxt) : (svbl | fvbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vs_q        <= 1'b1;
			vblank_q    <= 1'b1;
			vcnt        <= '0;
			vend        <= '0;
			vsta        <= '0;
			vmax        <= '0;
			vsize       <= '0;
			svbl        <= 1'b1;
			fvbl        <= 1'b1;
			frame_start <= 1'b0;
			de          <= 1'b0;
		end else begin
			vs_q        <= vs;
			vblank_q    <= vblank;
			frame_start <= vblank_fall;

			if (!vs)
				vcnt <= '0;
			else if (line_start)
				vcnt <= vcnt + 1'b1;

			if (vblank_fall)
				vend <= vcnt;
			if (vblank_rise) begin
				vsta  <= vcnt;
				vsize <= vcnt - vend;	// lines of this frame
			end
			if (vs_fall)
				vmax <= vcnt;

			if (hbl_fall) begin
				svbl <= svbl_nxt;
				fvbl <= fvbl_nxt;
			end

			de <= h_active & ~vbl_line & vs;
		end
	end

endmodule

// File: rtl/line_measure.sv
/*
 * line measurement
 * counts clocks per line, captures the hblank edges and the sync
 * position, measures the active width and builds the combined
 * horizontal blank from the soft crop and the forced margins
 */
`timescale 1ns/1ps

module line_measure #(
	parameter int cnt_w = video_timing_pkg::cnt_w_default
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             hs,
	input  logic             hblank,
	input  logic [cnt_w-1:0] crop_left,
	input  logic [cnt_w-1:0] crop_right,
	output logic             line_start,
	output logic             hbl_fall,
	output logic             h_active,
	output logic [cnt_w-1:0] hsize
);
	import video_timing_pkg::*;

	logic             hs_q;
	logic             hblank_q;
	logic             hbl_q;
	logic [cnt_w-1:0] hcnt;
	logic [cnt_w-1:0] hend;	// count at first active clock
	logic [cnt_w-1:0] hsta;	// count at first blank clock
	logic [cnt_w-1:0] hmax;	// count at sync start
	logic             shbl;
	logic             fhbl;
	logic             hbl;
	logic             hblank_fall;
	logic             hblank_rise;
	logic             hs_fall;
	logic [cnt_w-1:0] soft_off;
	logic [cnt_w-1:0] soft_on;

	assign hblank_fall = hblank_q & ~hblank;
	assign hblank_rise = ~hblank_q & hblank;
	assign hs_fall     = hs_q & ~hs;

	// compare one count early since shbl is a register
	assign soft_off = hend + crop_left - cnt_w'(1);
	assign soft_on  = hsta - crop_right - cnt_w'(1);

	assign hbl      = shbl | fhbl | ~hs;
	assign h_active = ~hbl;
	assign hbl_fall = hbl_q & ~hbl;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_q       <= 1'b1;
			hblank_q   <= 1'b1;
			hbl_q      <= 1'b1;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
			line_start <= 1'b0;
		end else begin
			hs_q       <= hs;
			hblank_q   <= hblank;
			hbl_q      <= hbl;
			line_start <= hs_fall;

			if (!hs)
				hcnt <= '0;	// held at zero through sync
			else
				hcnt <= hcnt + 1'b1;

			if (hblank_fall)
				hend <= hcnt;
			if (hblank_rise) begin
				hsta  <= hcnt;
				hsize <= hcnt - hend;	// active clocks of this line
			end
			if (hs_fall)
				hmax <= hcnt;

			// right edge uses the previous line's hsta
			if (hcnt == soft_off)
				shbl <= 1'b0;
			if (hcnt == soft_on)
				shbl <= 1'b1;

			if (hcnt == cnt_w'(h_force_lead))
				fhbl <= 1'b0;
			if (hcnt == hmax - cnt_w'(h_force_trail))
				fhbl <= 1'b1;
		end
	end

endmodule

// File: rtl/crop_regs_pkg.sv
/*
 * crop register block definitions
 * host bus widths, register map, keyboard codes and the key byte layout
 */
package crop_regs_pkg;

	localparam int wb_adr_w = 3;
	localparam int wb_dat_w = 16;

	localparam logic [wb_adr_w-1:0] reg_left   = 3'd0;	// read/write
	localparam logic [wb_adr_w-1:0] reg_right  = 3'd1;
	localparam logic [wb_adr_w-1:0] reg_top    = 3'd2;
	localparam logic [wb_adr_w-1:0] reg_bottom = 3'd3;
	localparam logic [wb_adr_w-1:0] reg_hsize  = 3'd4;	// read only
	localparam logic [wb_adr_w-1:0] reg_vsize  = 3'd5;
	localparam logic [wb_adr_w-1:0] reg_change = 3'd6;

	localparam logic [6:0] key_clear = 7'h41;	// backspace
	localparam logic [6:0] key_up    = 7'h4c;
	localparam logic [6:0] key_down  = 7'h4d;
	localparam logic [6:0] key_left  = 7'h4f;
	localparam logic [6:0] key_right = 7'h4e;
	localparam logic [6:0] key_alt_l = 7'h64;
	localparam logic [6:0] key_alt_r = 7'h65;

	localparam logic [1:0] kbd_type_key = 2'd3;	// keyboard byte, not mouse

	localparam int h_step = 4;	// clocks per left/right key press

	// key byte seen as a raw value or as flag and code
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       rel;	// set on key release
			logic [6:0] code;
		} fld;
	} key_byte_u;

endpackage

// File: rtl/video_timing_pkg.sv
/*
 * video timing constants
 * counter width and forced blank margins shared by the
 * line and frame measurement blocks
 */
package video_timing_pkg;

	localparam int cnt_w_default = 12;	// lines and frames up to 4095

	// forced horizontal blank in clocks, counted from the end of hsync
	localparam int h_force_lead  = 8;	// clocks after sync end
	localparam int h_force_trail = 8;	// clocks before next sync

	// forced vertical blank in lines
	localparam int v_force_lead  = 1;	// lines after vsync
	localparam int v_force_trail = 3;	// lines before max line count

endpackage
